/* Makefile */
# Verilator build and run of the frame_scheduler testbench

VERILATOR ?= verilator
TOP ?= tb_frame_scheduler
FILELIST ?= frame_scheduler.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* ctrl_msg_decoder.sv */
`default_nettype none

module ctrl_msg_decoder (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire [sched_cfg_pkg::DATA_WIDTH-1:0]    ctrl_in_tdata,
  input  wire                                    ctrl_in_tvalid,
  input  wire sched_cfg_pkg::core_id_t           ctrl_in_tuser,
  output logic                                   ctrl_in_tready,
  output logic [sched_cfg_pkg::CORE_COUNT-1:0]   slot_push,
  output sched_cfg_pkg::slot_t                   slot_push_data,
  output logic [sched_cfg_pkg::CORE_COUNT-1:0]   slot_clear,
  input  wire [sched_cfg_pkg::CORE_COUNT-1:0]    slot_push_ready,
  output logic                                   loopback_push,
  output sched_cfg_pkg::loopback_t               loopback_data,
  input  wire                                    loopback_ready
);

  logic [sched_msg_pkg::MSG_TYPE_WIDTH-1:0] msg_type;
  logic is_free;
  logic is_loop;
  logic is_load;
  logic accept;
  logic running;
  logic load_clear;
  logic load_busy;
  logic load_push;
  sched_cfg_pkg::core_id_t load_core;
  sched_cfg_pkg::slot_t load_next;
  sched_cfg_pkg::slot_t load_remain;
  sched_cfg_pkg::slot_t load_count;
  sched_cfg_pkg::slot_t req_count;

  assign msg_type = ctrl_in_tdata[sched_msg_pkg::MSG_TYPE_HI:sched_msg_pkg::MSG_TYPE_LO];
  assign is_free = (msg_type == sched_msg_pkg::MSG_SLOT_FREE);
  assign is_loop = (msg_type == sched_msg_pkg::MSG_LOOPBACK);
  assign is_load = (msg_type == sched_msg_pkg::MSG_SLOT_LOAD);

  assign load_busy = load_clear || (load_remain != '0);
  assign load_push = !load_clear && (load_remain != '0);

  // Unknown message types are taken and dropped
  always_comb begin
    ctrl_in_tready = 1'b0;
    if (running && !load_busy) begin
      if (is_free) begin
        ctrl_in_tready = slot_push_ready[ctrl_in_tuser];
      end else if (is_loop) begin
        ctrl_in_tready = loopback_ready;
      end else begin
        ctrl_in_tready = 1'b1;
      end
    end
  end

  assign accept = ctrl_in_tvalid && ctrl_in_tready;

  // A load never asks for more slots than the FIFO holds
  assign req_count = ctrl_in_tdata[sched_msg_pkg::LOAD_COUNT_LSB +: sched_cfg_pkg::SLOT_WIDTH];
  assign load_count = (req_count > sched_cfg_pkg::SLOT_WIDTH'(sched_cfg_pkg::SLOT_COUNT)) ?
                      sched_cfg_pkg::SLOT_WIDTH'(sched_cfg_pkg::SLOT_COUNT) : req_count;

  always_comb begin
    for (int i = 0; i < sched_cfg_pkg::CORE_COUNT; i++) begin
      slot_push[i] = (load_push && (load_core == i)) ||
                     (accept && is_free && (ctrl_in_tuser == i));
      slot_clear[i] = load_clear && (load_core == i);
    end
  end

  assign slot_push_data = load_push ? load_next :
    ctrl_in_tdata[sched_msg_pkg::FREE_SLOT_LSB +: sched_cfg_pkg::SLOT_WIDTH];

  assign loopback_push = accept && is_loop;
  assign loopback_data = '{core: ctrl_in_tuser, desc: ctrl_in_tdata};

  // Loader: clear the target FIFO, then push slots 1..N one per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      load_clear <= 1'b0;
      load_remain <= '0;
    end else begin
      running <= 1'b1;
      if (accept && is_load) begin
        load_clear <= 1'b1;
        load_remain <= load_count;
      end else if (load_clear) begin
        load_clear <= 1'b0;
      end else if (load_push && slot_push_ready[load_core]) begin
        load_remain <= load_remain - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && is_load) begin
      load_core <= ctrl_in_tuser;
      load_next <= sched_cfg_pkg::SLOT_WIDTH'(1);
    end else if (load_push && slot_push_ready[load_core]) begin
      load_next <= load_next + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* ctrl_out_mux.sv */
`default_nettype none

module ctrl_out_mux (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  loopback_valid,
  input  wire sched_cfg_pkg::loopback_t        loopback_data,
  output logic                                 loopback_pop,
  output logic [sched_cfg_pkg::DATA_WIDTH-1:0] ctrl_out_tdata,
  output sched_cfg_pkg::core_id_t              ctrl_out_tdest,
  output logic                                 ctrl_out_tvalid,
  input  wire                                  ctrl_out_tready
);

  // One extra bit so the counter can sit at CORE_COUNT when done
  logic [sched_cfg_pkg::CORE_ID_WIDTH:0] rst_cnt;
  logic in_reset_seq;

  assign in_reset_seq = (rst_cnt < sched_cfg_pkg::CORE_COUNT);

  always_ff @(posedge clk) begin
    if (rst) begin
      rst_cnt <= '0;
    end else if (in_reset_seq && ctrl_out_tready) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

  assign ctrl_out_tvalid = in_reset_seq || loopback_valid;
  assign loopback_pop = !in_reset_seq && loopback_valid && ctrl_out_tready;

  assign ctrl_out_tdest = in_reset_seq ? rst_cnt[sched_cfg_pkg::CORE_ID_WIDTH-1:0] :
                                         loopback_data.core;

  assign ctrl_out_tdata = in_reset_seq ? sched_msg_pkg::CORE_RESET_WORD :
    {{sched_msg_pkg::LOOPBACK_TYPE_MASK_BITS{1'b0}},
     loopback_data.desc[sched_cfg_pkg::DATA_WIDTH-sched_msg_pkg::LOOPBACK_TYPE_MASK_BITS-1:0]};

endmodule

`default_nettype wire

/* frame_dispatcher.sv */
`default_nettype none

module frame_dispatcher (
  input  wire                                                        clk,
  input  wire                                                        rst,
  input  wire [sched_cfg_pkg::PORT_COUNT-1:0]                        rx_tvalid,
  input  wire [sched_cfg_pkg::PORT_COUNT-1:0]                        rx_tlast,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0]                       rx_tready,
  input  wire [sched_cfg_pkg::PORT_COUNT-1:0]                        data_tready,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0]                       data_tvalid,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0][sched_cfg_pkg::DEST_WIDTH-1:0] data_tdest,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0][sched_cfg_pkg::PORT_WIDTH-1:0] data_tuser,
  input  wire [sched_cfg_pkg::CORE_COUNT-1:0]                        slot_valid,
  input  wire sched_cfg_pkg::slot_t [sched_cfg_pkg::CORE_COUNT-1:0]  slot_head,
  input  wire sched_cfg_pkg::slot_t [sched_cfg_pkg::CORE_COUNT-1:0]  slot_count,
  output logic [sched_cfg_pkg::CORE_COUNT-1:0]                       slot_pop
);

  sched_cfg_pkg::core_id_t best_core;
  sched_cfg_pkg::slot_t best_count;
  logic [sched_cfg_pkg::PORT_COUNT-1:0] held;
  logic [sched_cfg_pkg::PORT_COUNT-1:0] last_hs;
  logic [sched_cfg_pkg::PORT_COUNT-1:0] req;
  logic [sched_cfg_pkg::PORT_WIDTH-1:0] rr_ptr;
  logic [sched_cfg_pkg::PORT_WIDTH-1:0] grant_port;
  logic grant_valid;

  // Core with the most free slots, ties go to the lowest index
  always_comb begin
    best_core = '0;
    best_count = slot_count[0];
    for (int i = 1; i < sched_cfg_pkg::CORE_COUNT; i++) begin
      if (slot_count[i] > best_count) begin
        best_core = sched_cfg_pkg::core_id_t'(i);
        best_count = slot_count[i];
      end
    end
  end

  assign last_hs = rx_tvalid & rx_tlast & rx_tready;
  assign req = ~held | last_hs;

  // Round robin from rr_ptr; walking backwards lets the nearest requester win
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_port = rr_ptr;
    for (int k = sched_cfg_pkg::PORT_COUNT - 1; k >= 0; k--) begin
      idx = (int'(rr_ptr) + k) % sched_cfg_pkg::PORT_COUNT;
      if (req[idx]) begin
        grant_valid = slot_valid[best_core];
        grant_port = idx[sched_cfg_pkg::PORT_WIDTH-1:0];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < sched_cfg_pkg::CORE_COUNT; i++) begin
      slot_pop[i] = grant_valid && (best_core == i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= '0;
      rr_ptr <= '0;
    end else begin
      held <= held & ~last_hs;
      if (grant_valid) begin
        held[grant_port] <= 1'b1;
        rr_ptr <= (grant_port == sched_cfg_pkg::PORT_COUNT - 1) ? '0 : grant_port + 1'b1;
      end
    end
  end

  // Destination is core index above slot number
  always_ff @(posedge clk) begin
    if (grant_valid) begin
      data_tdest[grant_port] <= {best_core, slot_head[best_core]};
    end
  end

  assign data_tvalid = rx_tvalid & held;
  assign rx_tready = data_tready & held;

  always_comb begin
    for (int p = 0; p < sched_cfg_pkg::PORT_COUNT; p++) begin
      data_tuser[p] = p[sched_cfg_pkg::PORT_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

/* frame_scheduler.f */
sched_cfg_pkg.sv
sched_msg_pkg.sv
slot_fifo.sv
ctrl_msg_decoder.sv
frame_dispatcher.sv
ctrl_out_mux.sv
frame_scheduler.sv
tb_frame_scheduler.sv

/* frame_scheduler.sv */
`default_nettype none

module frame_scheduler (
  input  wire                                                        clk,
  input  wire                                                        rst,
  input  wire [sched_cfg_pkg::PORT_COUNT-1:0][sched_cfg_pkg::DATA_WIDTH-1:0] rx_tdata,
  input  wire [sched_cfg_pkg::PORT_COUNT-1:0][sched_cfg_pkg::KEEP_WIDTH-1:0] rx_tkeep,
  input  wire [sched_cfg_pkg::PORT_COUNT-1:0]                        rx_tvalid,
  input  wire [sched_cfg_pkg::PORT_COUNT-1:0]                        rx_tlast,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0]                       rx_tready,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0][sched_cfg_pkg::DATA_WIDTH-1:0] data_tdata,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0][sched_cfg_pkg::KEEP_WIDTH-1:0] data_tkeep,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0][sched_cfg_pkg::DEST_WIDTH-1:0] data_tdest,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0][sched_cfg_pkg::PORT_WIDTH-1:0] data_tuser,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0]                       data_tvalid,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0]                       data_tlast,
  input  wire [sched_cfg_pkg::PORT_COUNT-1:0]                        data_tready,
  input  wire [sched_cfg_pkg::DATA_WIDTH-1:0]                        ctrl_in_tdata,
  input  wire                                                        ctrl_in_tvalid,
  input  wire sched_cfg_pkg::core_id_t                               ctrl_in_tuser,
  output logic                                                       ctrl_in_tready,
  output logic [sched_cfg_pkg::DATA_WIDTH-1:0]                       ctrl_out_tdata,
  output sched_cfg_pkg::core_id_t                                    ctrl_out_tdest,
  output logic                                                       ctrl_out_tvalid,
  input  wire                                                        ctrl_out_tready
);

  logic [sched_cfg_pkg::CORE_COUNT-1:0] slot_push;
  logic [sched_cfg_pkg::CORE_COUNT-1:0] slot_clear;
  logic [sched_cfg_pkg::CORE_COUNT-1:0] slot_push_ready;
  logic [sched_cfg_pkg::CORE_COUNT-1:0] slot_valid;
  logic [sched_cfg_pkg::CORE_COUNT-1:0] slot_pop;
  sched_cfg_pkg::slot_t slot_push_data;
  sched_cfg_pkg::slot_t [sched_cfg_pkg::CORE_COUNT-1:0] slot_head;
  sched_cfg_pkg::slot_t [sched_cfg_pkg::CORE_COUNT-1:0] slot_count;

  logic loopback_push;
  logic loopback_ready;
  logic loopback_valid;
  logic loopback_pop;
  sched_cfg_pkg::loopback_t loopback_in;
  sched_cfg_pkg::loopback_t loopback_out;

  // Frame payload goes straight through, only tdest and tuser are added
  assign data_tdata = rx_tdata;
  assign data_tkeep = rx_tkeep;
  assign data_tlast = rx_tlast;

  ctrl_msg_decoder ctrl_msg_decoder_i (
    .clk             (clk),
    .rst             (rst),
    .ctrl_in_tdata   (ctrl_in_tdata),
    .ctrl_in_tvalid  (ctrl_in_tvalid),
    .ctrl_in_tuser   (ctrl_in_tuser),
    .ctrl_in_tready  (ctrl_in_tready),
    .slot_push       (slot_push),
    .slot_push_data  (slot_push_data),
    .slot_clear      (slot_clear),
    .slot_push_ready (slot_push_ready),
    .loopback_push   (loopback_push),
    .loopback_data   (loopback_in),
    .loopback_ready  (loopback_ready)
  );

  for (genvar i = 0; i < sched_cfg_pkg::CORE_COUNT; i++) begin : g_slot_fifo
    slot_fifo #(
      .DEPTH     (sched_cfg_pkg::SLOT_COUNT),
      .payload_t (sched_cfg_pkg::slot_t)
    ) slot_fifo_i (
      .clk        (clk),
      .rst        (rst),
      .clear      (slot_clear[i]),
      .push       (slot_push[i]),
      .push_data  (slot_push_data),
      .push_ready (slot_push_ready[i]),
      .pop_valid  (slot_valid[i]),
      .pop_data   (slot_head[i]),
      .pop        (slot_pop[i]),
      .count      (slot_count[i])
    );
  end

  // Loopback queue needs no occupancy, only valid and ready
  slot_fifo #(
    .DEPTH     (sched_cfg_pkg::LOOPBACK_DEPTH),
    .payload_t (sched_cfg_pkg::loopback_t)
  ) loopback_fifo_i (
    .clk        (clk),
    .rst        (rst),
    .clear      (1'b0),
    .push       (loopback_push),
    .push_data  (loopback_in),
    .push_ready (loopback_ready),
    .pop_valid  (loopback_valid),
    .pop_data   (loopback_out),
    .pop        (loopback_pop),
    .count      ()
  );

  frame_dispatcher frame_dispatcher_i (
    .clk         (clk),
    .rst         (rst),
    .rx_tvalid   (rx_tvalid),
    .rx_tlast    (rx_tlast),
    .rx_tready   (rx_tready),
    .data_tready (data_tready),
    .data_tvalid (data_tvalid),
    .data_tdest  (data_tdest),
    .data_tuser  (data_tuser),
    .slot_valid  (slot_valid),
    .slot_head   (slot_head),
    .slot_count  (slot_count),
    .slot_pop    (slot_pop)
  );

  ctrl_out_mux ctrl_out_mux_i (
    .clk             (clk),
    .rst             (rst),
    .loopback_valid  (loopback_valid),
    .loopback_data   (loopback_out),
    .loopback_pop    (loopback_pop),
    .ctrl_out_tdata  (ctrl_out_tdata),
    .ctrl_out_tdest  (ctrl_out_tdest),
    .ctrl_out_tvalid (ctrl_out_tvalid),
    .ctrl_out_tready (ctrl_out_tready)
  );

endmodule

`default_nettype wire

/* sched_cfg_pkg.sv */
`default_nettype none

package sched_cfg_pkg;

  // Ethernet ports and processing cores
  localparam int PORT_COUNT = 2;
  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 8;

  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  // Slots are numbered from 1, so a count of SLOT_COUNT needs one extra bit
  localparam int SLOT_WIDTH = $clog2(SLOT_COUNT + 1);
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);
  localparam int PORT_WIDTH = $clog2(PORT_COUNT);
  localparam int DEST_WIDTH = CORE_ID_WIDTH + SLOT_WIDTH;

  localparam int LOOPBACK_DEPTH = 16;

  typedef logic [SLOT_WIDTH-1:0] slot_t;
  typedef logic [CORE_ID_WIDTH-1:0] core_id_t;

  typedef struct packed {
    core_id_t              core;
    logic [DATA_WIDTH-1:0] desc;
  } loopback_t;

endpackage

`default_nettype wire

/* sched_msg_pkg.sv */
`default_nettype none

package sched_msg_pkg;

  // Message type sits in the top nibble of the control word
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int MSG_TYPE_HI = sched_cfg_pkg::DATA_WIDTH - 1;
  localparam int MSG_TYPE_LO = sched_cfg_pkg::DATA_WIDTH - MSG_TYPE_WIDTH;

  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SLOT_FREE = 4'd0;
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_LOOPBACK = 4'd1;
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SLOT_LOAD = 4'd3;

  // Field positions inside the message word
  localparam int FREE_SLOT_LSB = 16;
  localparam int LOAD_COUNT_LSB = 0;

  localparam logic [sched_cfg_pkg::DATA_WIDTH-1:0] CORE_RESET_WORD =
    64'hFFFF_FFFF_FFFF_FFFE;

  // Type byte of a looped-back descriptor is cleared so the core sends it out
  localparam int LOOPBACK_TYPE_MASK_BITS = 8;

endpackage

`default_nettype wire

/* slot_fifo.sv */
`default_nettype none

module slot_fifo #(
  parameter int DEPTH = 8,
  parameter type payload_t = logic [7:0]
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         clear,
  input  wire                         push,
  input  wire payload_t               push_data,
  output logic                        push_ready,
  output logic                        pop_valid,
  output payload_t                    pop_data,
  input  wire                         pop,
  output logic [$clog2(DEPTH+1)-1:0]  count
);

  localparam int PTR_WIDTH = $clog2(DEPTH);
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign push_ready = (count != CNT_WIDTH'(DEPTH));
  assign pop_valid = (count != '0);
  assign pop_data = mem[rd_ptr];

  // Clear takes priority over a push in the same cycle
  assign do_push = push && push_ready && !clear;
  assign do_pop = pop && pop_valid && !clear;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_WIDTH'(do_push) - CNT_WIDTH'(do_pop);
    end
  end

endmodule

`default_nettype wire

/* tb_frame_scheduler.sv */
`default_nettype none

module tb_frame_scheduler;

  localparam int NP = sched_cfg_pkg::PORT_COUNT;
  localparam int DW = sched_cfg_pkg::DATA_WIDTH;
  localparam int KW = sched_cfg_pkg::KEEP_WIDTH;
  localparam int DSW = sched_cfg_pkg::DEST_WIDTH;
  localparam int TIMEOUT = 500;

  logic clk;
  logic rst;
  logic [NP-1:0][DW-1:0] rx_tdata;
  logic [NP-1:0][KW-1:0] rx_tkeep;
  logic [NP-1:0] rx_tvalid;
  logic [NP-1:0] rx_tlast;
  logic [NP-1:0] rx_tready;
  logic [NP-1:0][DW-1:0] data_tdata;
  logic [NP-1:0][KW-1:0] data_tkeep;
  logic [NP-1:0][DSW-1:0] data_tdest;
  logic [NP-1:0][sched_cfg_pkg::PORT_WIDTH-1:0] data_tuser;
  logic [NP-1:0] data_tvalid;
  logic [NP-1:0] data_tlast;
  logic [NP-1:0] data_tready;
  logic [DW-1:0] ctrl_in_tdata;
  logic ctrl_in_tvalid;
  logic [1:0] ctrl_in_tuser;
  logic ctrl_in_tready;
  logic [DW-1:0] ctrl_out_tdata;
  logic [1:0] ctrl_out_tdest;
  logic ctrl_out_tvalid;
  logic ctrl_out_tready;

  logic [15:0] lfsr;
  int errors;
  int checks;
  int tests;
  logic stall_en;
  logic ctrl_stall_en;
  logic loaded;
  logic [NP-1:0] dest_check_en;
  logic [DSW-1:0] exp_dest [NP];
  logic [DW+1:0] exp_ctrl [$];
  logic [DW+1:0] ctrl_word;
  // Reference model of the slot FIFOs
  logic [3:0] core_q [4][$];
  logic in_use [4][16];
  logic [NP-1:0] sof;
  logic [DSW-1:0] frame_dest [NP];
  logic have0;
  logic have1;
  logic [DSW-1:0] dest0;
  logic [DSW-1:0] dest1;
  logic [DW-1:0] desc;

  frame_scheduler dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic next_bit();
    next_bit = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], next_bit()};
    end
    return v;
  endfunction

  // Ready stalls on the frame outputs and the control output
  initial begin
    data_tready = '1;
    ctrl_out_tready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      for (int p = 0; p < NP; p++) begin
        data_tready[p] = stall_en ? (next_bit() | next_bit()) : 1'b1;
      end
      ctrl_out_tready = ctrl_stall_en ? next_bit() : 1'b1;
    end
  end

  task automatic model_grant(output logic ok, output logic [DSW-1:0] dest);
    int best;
    best = 0;
    for (int c = 1; c < 4; c++) begin
      if (core_q[c].size() > core_q[best].size()) begin
        best = c;
      end
    end
    ok = (core_q[best].size() != 0);
    dest = '0;
    if (ok) begin
      dest = {2'(best), core_q[best].pop_front()};
    end
  endtask

  task automatic send_ctrl(input logic [1:0] core, input logic [DW-1:0] word);
    int t;
    @(posedge clk);
    #1;
    ctrl_in_tdata = word;
    ctrl_in_tuser = core;
    ctrl_in_tvalid = 1'b1;
    t = 0;
    @(negedge clk);
    while (!ctrl_in_tready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!ctrl_in_tready) begin
      errors++;
      $display("Timeout: control message to core %0d was never accepted", core);
    end
    @(posedge clk);
    #1;
    ctrl_in_tvalid = 1'b0;
  endtask

  task automatic load_core(input int core, input int n);
    core_q[core].delete();
    for (int s = 1; s <= n; s++) begin
      core_q[core].push_back(4'(s));
      in_use[core][s] = 1'b0;
    end
    send_ctrl(2'(core), (DW'(sched_msg_pkg::MSG_SLOT_LOAD) << sched_msg_pkg::MSG_TYPE_LO) | DW'(n));
  endtask

  task automatic free_slot(input int core, input int slot);
    core_q[core].push_back(4'(slot));
    in_use[core][slot] = 1'b0;
    send_ctrl(2'(core), DW'(slot) << sched_msg_pkg::FREE_SLOT_LSB);
  endtask

  task automatic send_frame(input int p, input int len);
    int t;
    for (int w = 0; w < len; w++) begin
      @(posedge clk);
      #1;
      rx_tdata[p] = rand_bits(DW);
      rx_tkeep[p] = (w == len - 1) ? (KW'(rand_bits(KW)) | KW'(1)) : '1;
      rx_tlast[p] = (w == len - 1);
      rx_tvalid[p] = 1'b1;
      t = 0;
      @(negedge clk);
      while (!rx_tready[p] && t < TIMEOUT) begin
        @(negedge clk);
        t++;
      end
      if (!rx_tready[p]) begin
        errors++;
        $display("Timeout: port %0d word %0d was never accepted", p, w);
      end
    end
    @(posedge clk);
    #1;
    rx_tvalid[p] = 1'b0;
    rx_tlast[p] = 1'b0;
  endtask

  task automatic send_frames(input int p, input int n);
    for (int i = 0; i < n; i++) begin
      send_frame(p, 1 + int'(rand_bits(2)));
    end
  endtask

  task automatic expect_blocked(input int p, input int cycles);
    @(posedge clk);
    #1;
    rx_tlast[p] = 1'b1;
    rx_tvalid[p] = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      checks++;
      assert (!rx_tready[p]) else begin
        errors++;
        $display("** Error: rx_tready[%0d] = %h, expected 0", p, rx_tready[p]);
      end
    end
    @(posedge clk);
    #1;
    rx_tvalid[p] = 1'b0;
    rx_tlast[p] = 1'b0;
  endtask

  task automatic wait_ctrl_drained();
    int t;
    t = 0;
    while (exp_ctrl.size() != 0 && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (exp_ctrl.size() != 0) begin
      errors++;
      $display("Timeout: %0d control output words never arrived", exp_ctrl.size());
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d (%s) finished, %0d errors so far", tests, name, errors);
  endtask

  a_first_cycle_idle: assert property (@(posedge clk)
    $fell(rst) |-> (rx_tready == '0 && data_tvalid == '0 && !ctrl_in_tready))
    else begin
      errors++;
      $display("** Error: after reset rx_tready = %h, data_tvalid = %h, ctrl_in_tready = %h",
               rx_tready, data_tvalid, ctrl_in_tready);
    end

  a_ctrl_hold: assert property (@(posedge clk) disable iff (rst)
    (ctrl_out_tvalid && !ctrl_out_tready) |=>
    (ctrl_out_tvalid && $stable(ctrl_out_tdata) && $stable(ctrl_out_tdest)))
    else begin
      errors++;
      $display("** Error: ctrl_out_tdata = %h changed while stalled", ctrl_out_tdata);
    end

  a_gating: assert property (@(posedge clk) disable iff (rst)
    ((data_tvalid & ~rx_tvalid) == '0) && ((rx_tready & ~data_tready) == '0))
    else begin
      errors++;
      $display("** Error: data_tvalid = %h, rx_tready = %h not gated by the inputs",
               data_tvalid, rx_tready);
    end

  always @(negedge clk) begin
    if (!rst && !loaded) begin
      checks++;
      assert (rx_tready == '0 && data_tvalid == '0) else begin
        errors++;
        $display("** Error: rx_tready = %h, data_tvalid = %h before any load, expected 0",
                 rx_tready, data_tvalid);
      end
    end
    if (!rst && ctrl_out_tvalid && ctrl_out_tready) begin
      checks++;
      if (exp_ctrl.size() == 0) begin
        errors++;
        $display("Unexpected control output word to core %0d", ctrl_out_tdest);
      end else begin
        ctrl_word = exp_ctrl.pop_front();
        assert ({ctrl_out_tdest, ctrl_out_tdata} == ctrl_word) else begin
          errors++;
          $display("** Error: ctrl_out_tdest/tdata = %h/%h, expected %h/%h",
                   ctrl_out_tdest, ctrl_out_tdata, ctrl_word[DW+1:DW], ctrl_word[DW-1:0]);
        end
      end
    end
  end

  always @(negedge clk) begin
    for (int p = 0; p < NP; p++) begin
      if (!rst && data_tvalid[p] && data_tready[p]) begin
        checks++;
        assert (data_tuser[p] == sched_cfg_pkg::PORT_WIDTH'(p)) else begin
          errors++;
          $display("** Error: data_tuser[%0d] = %h, expected %h", p, data_tuser[p], p);
        end
        assert (data_tdata[p] == rx_tdata[p]) else begin
          errors++;
          $display("** Error: data_tdata[%0d] = %h, expected %h", p, data_tdata[p], rx_tdata[p]);
        end
        assert (data_tkeep[p] == rx_tkeep[p] && data_tlast[p] == rx_tlast[p]) else begin
          errors++;
          $display("** Error: data_tkeep/tlast[%0d] = %h/%h, expected %h/%h",
                   p, data_tkeep[p], data_tlast[p], rx_tkeep[p], rx_tlast[p]);
        end
        if (sof[p]) begin
          frame_dest[p] = data_tdest[p];
          if (in_use[data_tdest[p][DSW-1:4]][data_tdest[p][3:0]]) begin
            errors++;
            $display("Core %0d slot %0d was given out twice without a free",
                     data_tdest[p][DSW-1:4], data_tdest[p][3:0]);
          end
          in_use[data_tdest[p][DSW-1:4]][data_tdest[p][3:0]] = 1'b1;
          if (dest_check_en[p]) begin
            assert (data_tdest[p] == exp_dest[p]) else begin
              errors++;
              $display("** Error: data_tdest[%0d] = %h, expected %h", p, data_tdest[p],
                       exp_dest[p]);
            end
            dest_check_en[p] = 1'b0;
          end
        end else begin
          assert (data_tdest[p] == frame_dest[p]) else begin
            errors++;
            $display("** Error: data_tdest[%0d] = %h, expected %h", p, data_tdest[p],
                     frame_dest[p]);
          end
        end
        sof[p] = data_tlast[p];
      end
    end
  end

  initial begin
    lfsr = 16'd79;
    errors = 0;
    checks = 0;
    tests = 0;
    stall_en = 1'b0;
    ctrl_stall_en = 1'b0;
    loaded = 1'b0;
    dest_check_en = '0;
    exp_dest = '{default: '0};
    sof = '1;
    for (int c = 0; c < 4; c++) begin
      for (int s = 0; s < 16; s++) begin
        in_use[c][s] = 1'b0;
      end
    end
    rst = 1'b1;
    rx_tdata = '0;
    rx_tkeep = '0;
    rx_tvalid = '1;
    rx_tlast = '1;
    ctrl_in_tdata = '0;
    ctrl_in_tvalid = 1'b0;
    ctrl_in_tuser = '0;
    for (int c = 0; c < 4; c++) begin
      exp_ctrl.push_back({2'(c), sched_msg_pkg::CORE_RESET_WORD});
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    wait_ctrl_drained();
    @(posedge clk);
    #1;
    rx_tvalid = '0;
    rx_tlast = '0;
    finish_test("reset sequence");

    // Both idle ports take core 0's slots while it loads
    loaded = 1'b1;
    load_core(0, 2);
    model_grant(have0, dest0);
    model_grant(have1, dest1);
    load_core(1, 5);
    load_core(2, 5);
    load_core(3, 1);
    while (have0) begin
      exp_dest[0] = dest0;
      dest_check_en[0] = 1'b1;
      send_frame(0, 1 + int'(rand_bits(2)));
      model_grant(have0, dest0);
    end
    finish_test("slot load and selection");

    expect_blocked(0, 12);
    free_slot(2, 7);
    model_grant(have0, dest0);
    exp_dest[0] = dest0;
    dest_check_en[0] = 1'b1;
    send_frame(0, 2);
    finish_test("exhaustion and free");

    stall_en = 1'b1;
    free_slot(0, 1);
    for (int s = 1; s <= 5; s++) begin
      free_slot(1, s);
    end
    free_slot(2, 1);
    free_slot(3, 1);
    // Port 1 has held core 0's second slot since the loads
    exp_dest[1] = dest1;
    dest_check_en[1] = have1;
    fork
      send_frames(0, 3);
      send_frames(1, 3);
    join
    stall_en = 1'b0;
    finish_test("two ports under stall");

    ctrl_stall_en = 1'b1;
    for (int i = 0; i < 4; i++) begin
      desc = rand_bits(DW - 4);
      desc[sched_msg_pkg::MSG_TYPE_HI:sched_msg_pkg::MSG_TYPE_LO] = sched_msg_pkg::MSG_LOOPBACK;
      exp_ctrl.push_back({(i % 2 == 0) ? 2'd1 : 2'd3, desc & 64'h00FF_FFFF_FFFF_FFFF});
      send_ctrl((i % 2 == 0) ? 2'd1 : 2'd3, desc);
    end
    wait_ctrl_drained();
    ctrl_stall_en = 1'b0;
    finish_test("loopback");

    $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
